// File: hdl/irs_cfg.svh
`ifndef IRS_CFG_SVH
`define IRS_CFG_SVH

////////////////////////////////////////////////////////////
// Board and datapath sizes
////////////////////////////////////////////////////////////

// Daughterboards on the carrier
`define IRS_NUM_DAUGHTERS    4
// APB word address and data bus widths
`define IRS_APB_ADDR_W       8
`define IRS_APB_DATA_W       16
// Wilkinson monitor count, saturates at all ones
`define IRS_MON_W            10
// Bias and Wilkinson counter settings
`define IRS_DAC_W            12

// Setting values after reset
`define IRS_SBBIAS_DEFAULT   12'h7FF
`define IRS_WILKCNT_DEFAULT  12'd620

////////////////////////////////////////////////////////////
// Register map, word addresses
////////////////////////////////////////////////////////////

`define IRS_ADDR_CTL         8'h00
`define IRS_ADDR_MONCTL      8'h01
`define IRS_ADDR_SBBIAS      8'h02
`define IRS_ADDR_WILKCNT     8'h03
`define IRS_ADDR_MONSTAT     8'h04
// Daughter d count lives at WILKMON0 + d
`define IRS_ADDR_WILKMON0    8'h08

// Field positions inside CTL
`define IRS_CTL_EN_BIT       0
`define IRS_CTL_NREFCLK_BIT  2
`define IRS_CTL_DEN_LSB      8

`endif

// File: hdl/irs_pkg.sv
package irs_pkg;

`include "irs_cfg.svh"

	////////////////////////////////////////////////////////////
	// Bus types
	////////////////////////////////////////////////////////////

	// Word address on the APB port
	typedef logic [`IRS_APB_ADDR_W-1:0] apb_addr_t;
	// Read and write data
	typedef logic [`IRS_APB_DATA_W-1:0] apb_data_t;

	////////////////////////////////////////////////////////////
	// Board types
	////////////////////////////////////////////////////////////

	// Bias or Wilkinson counter setting
	typedef logic [`IRS_DAC_W-1:0] dac_t;
	// Edge count of one monitor run
	typedef logic [`IRS_MON_W-1:0] mon_cnt_t;
	// One bit per daughterboard
	typedef logic [`IRS_NUM_DAUGHTERS-1:0] daughter_vec_t;

	// Wilkinson monitor FSM
	typedef enum logic [1:0] {
		MON_IDLE,
		MON_COUNT,
		MON_LATCH
	} mon_state_e;

endpackage

// File: hdl/irs_apb_regs.sv
`include "irs_cfg.svh"

module irs_apb_regs
	import irs_pkg::*;
(
	input  logic          clk_i,
	input  logic          irs_rst,
	// APB slave
	input  logic          psel_i,
	input  logic          penable_i,
	input  logic          pwrite_i,
	input  apb_addr_t     paddr_i,
	input  apb_data_t     pwdata_i,
	output apb_data_t     prdata_o,
	output logic          pready_o,
	output logic          pslverr_o,
	// Monitor results from the collector
	input  mon_cnt_t      mon_count_i [`IRS_NUM_DAUGHTERS],
	input  daughter_vec_t mon_new_i,
	output daughter_vec_t mon_clear_o,
	// Control to the daughter monitors and the board
	output daughter_vec_t daughter_en_o,
	output daughter_vec_t mon_run_o,
	output logic          refclk_en_o,
	output dac_t          sbbias_o,
	output dac_t          wilkcnt_o
);

	// Transfer phase decode
	logic          setup_w;
	logic          access_w;
	logic          rdy_nxt_w;
	logic          wr_en_w;
	logic          rd_done_w;
	// Address decode and read mux
	logic          addr_ok_w;
	apb_data_t     rd_data_w;
	// Response registers
	logic          pready_q;
	logic          pslverr_q;
	apb_data_t     prdata_q;
	// Control registers
	logic          glob_en_q;
	logic          n_refclk_q;
	daughter_vec_t dtr_en_q;
	daughter_vec_t run_q;
	dac_t          sbbias_q;
	dac_t          wilkcnt_q;

	////////////////////////////////////////////////////////////
	// APB handshake
	////////////////////////////////////////////////////////////

	assign setup_w  = psel_i & ~penable_i;
	assign access_w = psel_i & penable_i;

	// Writes are ready in the first access cycle
	// reads get one wait state, ready in the second
	assign rdy_nxt_w = (setup_w & pwrite_i) | (access_w & ~pwrite_i & ~pready_q);

	// Completing edges
	assign wr_en_w   = access_w & pwrite_i & pready_q;
	assign rd_done_w = access_w & ~pwrite_i & pready_q;

	always_ff @(posedge clk_i) begin
		if (irs_rst) begin
			pready_q  <= 1'b0;
			pslverr_q <= 1'b0;
		end else begin
			pready_q  <= rdy_nxt_w;
			// Error goes out with ready, only for holes in the map
			pslverr_q <= rdy_nxt_w & ~addr_ok_w;
		end
	end

	// Read data captured in the wait state
	always_ff @(posedge clk_i) begin
		if (access_w & ~pwrite_i & ~pready_q)
			prdata_q <= rd_data_w;
	end

	assign pready_o  = pready_q;
	assign pslverr_o = pslverr_q;
	assign prdata_o  = prdata_q;

	////////////////////////////////////////////////////////////
	// Read mux and address check
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_data_w = '0;
		addr_ok_w = 1'b1;
		case (paddr_i)
			`IRS_ADDR_CTL: begin
				rd_data_w[`IRS_CTL_EN_BIT]                          = glob_en_q;
				rd_data_w[`IRS_CTL_NREFCLK_BIT]                     = n_refclk_q;
				rd_data_w[`IRS_CTL_DEN_LSB +: `IRS_NUM_DAUGHTERS]   = dtr_en_q;
			end
			`IRS_ADDR_MONCTL:  rd_data_w[`IRS_NUM_DAUGHTERS-1:0] = run_q;
			`IRS_ADDR_SBBIAS:  rd_data_w[`IRS_DAC_W-1:0]         = sbbias_q;
			`IRS_ADDR_WILKCNT: rd_data_w[`IRS_DAC_W-1:0]         = wilkcnt_q;
			`IRS_ADDR_MONSTAT: rd_data_w[`IRS_NUM_DAUGHTERS-1:0] = mon_new_i;
			default: begin
				// Monitor counts, one word per daughter
				addr_ok_w = 1'b0;
				for (int d = 0; d < `IRS_NUM_DAUGHTERS; d++) begin
					if (paddr_i == apb_addr_t'(`IRS_ADDR_WILKMON0 + d)) begin
						rd_data_w[`IRS_MON_W-1:0] = mon_count_i[d];
						addr_ok_w                 = 1'b1;
					end
				end
			end
		endcase
	end

	// Flags that were returned get cleared as the MONSTAT read completes
	assign mon_clear_o = (rd_done_w && paddr_i == `IRS_ADDR_MONSTAT) ?
		prdata_q[`IRS_NUM_DAUGHTERS-1:0] : '0;

	////////////////////////////////////////////////////////////
	// Control and setting registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (irs_rst) begin
			glob_en_q  <= 1'b0;
			n_refclk_q <= 1'b0;
			dtr_en_q   <= '0;
			run_q      <= '0;
			sbbias_q   <= `IRS_SBBIAS_DEFAULT;
			wilkcnt_q  <= `IRS_WILKCNT_DEFAULT;
		end else if (wr_en_w) begin
			case (paddr_i)
				`IRS_ADDR_CTL: begin
					glob_en_q  <= pwdata_i[`IRS_CTL_EN_BIT];
					n_refclk_q <= pwdata_i[`IRS_CTL_NREFCLK_BIT];
					dtr_en_q   <= pwdata_i[`IRS_CTL_DEN_LSB +: `IRS_NUM_DAUGHTERS];
				end
				`IRS_ADDR_MONCTL:  run_q     <= pwdata_i[`IRS_NUM_DAUGHTERS-1:0];
				`IRS_ADDR_SBBIAS:  sbbias_q  <= pwdata_i[`IRS_DAC_W-1:0];
				`IRS_ADDR_WILKCNT: wilkcnt_q <= pwdata_i[`IRS_DAC_W-1:0];
				// MONSTAT, WILKMON and unmapped words hold nothing writable
				default: ;
			endcase
		end
	end

	// Daughter only runs with the global enable set too
	assign daughter_en_o = dtr_en_q & {`IRS_NUM_DAUGHTERS{glob_en_q}};
	assign mon_run_o     = run_q;
	// Reference clock bit is stored inverted
	assign refclk_en_o   = ~n_refclk_q;
	assign sbbias_o      = sbbias_q;
	assign wilkcnt_o     = wilkcnt_q;

endmodule

// File: hdl/irs_daughter_mon.sv
module irs_daughter_mon
	import irs_pkg::*;
(
	input  logic     clk_i,
	input  logic     irs_rst,
	// Daughter enable, gates counting
	input  logic     en_i,
	// Monitor run bit from the register block
	input  logic     run_i,
	// Wilkinson strobe of this daughter
	input  logic     strobe_i,
	// Count of the last finished run
	output mon_cnt_t count_o,
	// One cycle pulse with a new count_o
	output logic     update_o
);

	mon_state_e state_q;
	// Registered copies for edge detection
	logic       run_q;
	logic       strobe_q;
	logic       update_q;
	logic       run_rise_w;
	logic       run_fall_w;
	logic       strobe_rise_w;
	logic       cnt_inc_w;
	// Running count and latched result
	mon_cnt_t   cnt_q;
	mon_cnt_t   count_q;

	assign run_rise_w    = run_i & ~run_q;
	assign run_fall_w    = ~run_i & run_q;
	assign strobe_rise_w = strobe_i & ~strobe_q;

	// Count only while running and enabled, hold at all ones
	assign cnt_inc_w = (state_q == MON_COUNT) && run_i && strobe_rise_w && en_i &&
		(cnt_q != '1);

	////////////////////////////////////////////////////////////
	// Monitor FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (irs_rst) begin
			state_q  <= MON_IDLE;
			run_q    <= 1'b0;
			strobe_q <= 1'b0;
			update_q <= 1'b0;
		end else begin
			run_q    <= run_i;
			strobe_q <= strobe_i;
			update_q <= 1'b0;
			case (state_q)
				MON_IDLE: begin
					if (run_rise_w)
						state_q <= MON_COUNT;
				end
				MON_COUNT: begin
					if (run_fall_w)
						state_q <= MON_LATCH;
				end
				MON_LATCH: begin
					// Result goes out next cycle
					update_q <= 1'b1;
					state_q  <= MON_IDLE;
				end
				default: state_q <= MON_IDLE;
			endcase
		end
	end

	// Counter and result latch
	always_ff @(posedge clk_i) begin
		if (state_q == MON_IDLE && run_rise_w)
			cnt_q <= '0;
		else if (cnt_inc_w)
			cnt_q <= cnt_q + 1'b1;
		if (state_q == MON_LATCH)
			count_q <= cnt_q;
	end

	assign count_o  = count_q;
	assign update_o = update_q;

endmodule

// File: hdl/irs_mon_collect.sv
`include "irs_cfg.svh"

module irs_mon_collect
	import irs_pkg::*;
(
	input  logic          clk_i,
	input  logic          irs_rst,
	// Update pulses and counts from the daughter monitors
	input  daughter_vec_t update_i,
	input  mon_cnt_t      count_i [`IRS_NUM_DAUGHTERS],
	// Read-clear from the register block
	input  daughter_vec_t clear_i,
	// Stored counts and new-value flags
	output mon_cnt_t      count_o [`IRS_NUM_DAUGHTERS],
	output daughter_vec_t new_o
);

	mon_cnt_t      count_q [`IRS_NUM_DAUGHTERS];
	daughter_vec_t new_q;

	////////////////////////////////////////////////////////////
	// Sticky flags
	////////////////////////////////////////////////////////////

	// Set wins, so a result landing on the clearing read stays flagged
	always_ff @(posedge clk_i) begin
		if (irs_rst)
			new_q <= '0;
		else
			new_q <= update_i | (new_q & ~clear_i);
	end

	////////////////////////////////////////////////////////////
	// Count storage
	////////////////////////////////////////////////////////////

	// Last finished count per daughter, zero until the first run ends
	always_ff @(posedge clk_i) begin
		if (irs_rst) begin
			for (int d = 0; d < `IRS_NUM_DAUGHTERS; d++)
				count_q[d] <= '0;
		end else begin
			for (int d = 0; d < `IRS_NUM_DAUGHTERS; d++) begin
				if (update_i[d])
					count_q[d] <= count_i[d];
			end
		end
	end

	assign count_o = count_q;
	assign new_o   = new_q;

endmodule

// File: hdl/irs_ctrl_top.sv
`include "irs_cfg.svh"

module irs_ctrl_top
	import irs_pkg::*;
(
	input  logic          clk_i,
	input  logic          irs_rst,
	// APB slave port
	input  logic          psel_i,
	input  logic          penable_i,
	input  logic          pwrite_i,
	input  apb_addr_t     paddr_i,
	input  apb_data_t     pwdata_i,
	output apb_data_t     prdata_o,
	output logic          pready_o,
	output logic          pslverr_o,
	// Wilkinson strobes, one per daughter
	input  daughter_vec_t wilk_strobe_i,
	// Board controls
	output daughter_vec_t daughter_en_o,
	output logic          refclk_en_o,
	output dac_t          sbbias_o,
	output dac_t          wilkcnt_o
);

	// Register block to monitors
	daughter_vec_t daughter_en_w;
	daughter_vec_t mon_run_w;
	// Monitors to collector
	daughter_vec_t mon_update_w;
	mon_cnt_t      mon_count_w [`IRS_NUM_DAUGHTERS];
	// Collector and register block
	mon_cnt_t      store_count_w [`IRS_NUM_DAUGHTERS];
	daughter_vec_t mon_new_w;
	daughter_vec_t mon_clear_w;

	////////////////////////////////////////////////////////////
	// APB registers
	////////////////////////////////////////////////////////////

	irs_apb_regs u_regs (
		.clk_i         (clk_i),
		.irs_rst       (irs_rst),
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.pwrite_i      (pwrite_i),
		.paddr_i       (paddr_i),
		.pwdata_i      (pwdata_i),
		.prdata_o      (prdata_o),
		.pready_o      (pready_o),
		.pslverr_o     (pslverr_o),
		.mon_count_i   (store_count_w),
		.mon_new_i     (mon_new_w),
		.mon_clear_o   (mon_clear_w),
		.daughter_en_o (daughter_en_w),
		.mon_run_o     (mon_run_w),
		.refclk_en_o   (refclk_en_o),
		.sbbias_o      (sbbias_o),
		.wilkcnt_o     (wilkcnt_o)
	);

	assign daughter_en_o = daughter_en_w;

	////////////////////////////////////////////////////////////
	// Per-daughter Wilkinson monitors
	////////////////////////////////////////////////////////////

	for (genvar d = 0; d < `IRS_NUM_DAUGHTERS; d++) begin : g_dtr
		irs_daughter_mon u_mon (
			.clk_i    (clk_i),
			.irs_rst  (irs_rst),
			.en_i     (daughter_en_w[d]),
			.run_i    (mon_run_w[d]),
			.strobe_i (wilk_strobe_i[d]),
			.count_o  (mon_count_w[d]),
			.update_o (mon_update_w[d])
		);
	end

	// Result storage and flags for readback
	irs_mon_collect u_collect (
		.clk_i    (clk_i),
		.irs_rst  (irs_rst),
		.update_i (mon_update_w),
		.count_i  (mon_count_w),
		.clear_i  (mon_clear_w),
		.count_o  (store_count_w),
		.new_o    (mon_new_w)
	);

endmodule

// File: verif/irs_properties.sv
module irs_properties
	import irs_pkg::*;
(
	input logic          clk_i,
	input logic          irs_rst,
	input logic          psel_i,
	input logic          penable_i,
	input logic          pready_o,
	input logic          pslverr_o,
	input daughter_vec_t mon_update_i
);

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////////////////////////
	// APB response rules
	////////////////////////////////////////////////////////////

	// Ready only ever comes up inside an access phase
	ready_in_access: assert property (@(posedge clk_i) disable iff (irs_rst)
		$rose(pready_o) |-> (psel_i && penable_i))
		else $error("pready rose outside an access phase");

	// Error is only ever given along with ready, inside an access phase
	err_with_ready: assert property (@(posedge clk_i) disable iff (irs_rst)
		pslverr_o |-> (pready_o && psel_i && penable_i))
		else $error("pslverr high without pready in an access phase");

	////////////////////////////////////////////////////////////
	// Monitor update pulses
	////////////////////////////////////////////////////////////

	// No daughter holds its update for two cycles in a row
	update_one_cycle: assert property (@(posedge clk_i) disable iff (irs_rst)
		(mon_update_i & $past(mon_update_i)) == '0)
		else $error("monitor update pulse longer than one cycle");

endmodule

bind irs_ctrl_top irs_properties u_props (
	.clk_i        (clk_i),
	.irs_rst      (irs_rst),
	.psel_i       (psel_i),
	.penable_i    (penable_i),
	.pready_o     (pready_o),
	.pslverr_o    (pslverr_o),
	.mon_update_i (mon_update_w)
);

// File: verif/irs_tb.sv
`include "irs_cfg.svh"

module irs_tb
	import irs_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic          clk_i;
	logic          irs_rst;
	logic          psel;
	logic          penable;
	logic          pwrite;
	apb_addr_t     paddr;
	apb_data_t     pwdata;
	apb_data_t     prdata;
	logic          pready;
	logic          pslverr;
	daughter_vec_t strobe;
	daughter_vec_t daughter_en;
	logic          refclk_en;
	dac_t          sbbias;
	dac_t          wilkcnt;
	// Failure counters for the closing line
	int            errors;
	int            timeouts;
	int unsigned   seed_val;

	irs_ctrl_top u_dut (
		.clk_i         (clk_i),
		.irs_rst       (irs_rst),
		.psel_i        (psel),
		.penable_i     (penable),
		.pwrite_i      (pwrite),
		.paddr_i       (paddr),
		.pwdata_i      (pwdata),
		.prdata_o      (prdata),
		.pready_o      (pready),
		.pslverr_o     (pslverr),
		.wilk_strobe_i (strobe),
		.daughter_en_o (daughter_en),
		.refclk_en_o   (refclk_en),
		.sbbias_o      (sbbias),
		.wilkcnt_o     (wilkcnt)
	);

	// 10 ns clock
	always #5 clk_i = ~clk_i;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// APB master
	////////////////////////////////////////////////////////////

	// One transfer, returns 1 ns after the completing edge
	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		int waits;
		waits = 0;
		@(posedge clk_i);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk_i);
		#1;
		penable = 1'b1;
		// Ready sampled mid-cycle where it is stable
		@(negedge clk_i);
		while (pready !== 1'b1 && waits < 20) begin
			waits++;
			@(negedge clk_i);
		end
		if (pready !== 1'b1) begin
			timeouts++;
			$display("Timeout: no pready for the transfer to address %h", addr);
		end else begin
			// Writes finish in the first access cycle, reads one cycle later
			check_value("pready wait states", waits, wr ? 0 : 1);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk_i);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// Writes are expected to complete without error
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		apb_data_t unused;
		logic      err;
		apb_xfer(1'b1, addr, data, unused, err);
		check_value("pslverr on write", err, 0);
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		apb_xfer(1'b0, addr, 16'h0000, data, err);
	endtask

	// Single-cycle high pulses on one strobe
	task automatic pulse_strobe(input int d, input int pulses);
		repeat (pulses) begin
			@(posedge clk_i);
			#1 strobe[d] = 1'b1;
			@(posedge clk_i);
			#1 strobe[d] = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_values();
		apb_data_t rd;
		logic      err;
		apb_read(`IRS_ADDR_SBBIAS, rd, err);
		check_value("SBBIAS after reset", rd, 16'h07FF);
		apb_read(`IRS_ADDR_WILKCNT, rd, err);
		check_value("WILKCNT after reset", rd, 16'd620);
		apb_read(`IRS_ADDR_CTL, rd, err);
		check_value("CTL after reset", rd, 16'h0000);
		check_value("refclk_en_o after reset", refclk_en, 1);
		check_value("daughter_en_o after reset", daughter_en, 0);
	endtask

	// CTL value, then enables and refclk checked against the bit rules
	task automatic write_ctl_check(input apb_data_t val);
		apb_data_t rd;
		logic      err;
		apb_write(`IRS_ADDR_CTL, val);
		apb_read(`IRS_ADDR_CTL, rd, err);
		check_value("CTL readback", rd, val);
		check_value("daughter_en_o", daughter_en, val[11:8] & {4{val[0]}});
		check_value("refclk_en_o", refclk_en, !val[2]);
	endtask

	task automatic test_ctl_settings();
		apb_data_t rd;
		logic      err;
		write_ctl_check(16'h0A05);
		write_ctl_check(16'h0F00);
		write_ctl_check(16'h0501);
		apb_write(`IRS_ADDR_SBBIAS, 16'h0123);
		apb_write(`IRS_ADDR_WILKCNT, 16'h0ABC);
		apb_read(`IRS_ADDR_SBBIAS, rd, err);
		check_value("SBBIAS readback", rd, 16'h0123);
		apb_read(`IRS_ADDR_WILKCNT, rd, err);
		check_value("WILKCNT readback", rd, 16'h0ABC);
		check_value("sbbias_o", sbbias, 12'h123);
		check_value("wilkcnt_o", wilkcnt, 12'hABC);
	endtask

	// Full run on one daughter, then flag poll and count readback
	task automatic monitor_run(input int d, input int pulses, input int exp_count);
		apb_data_t rd;
		logic      err;
		logic      seen;
		int        tries;
		seen  = 1'b0;
		tries = 0;
		apb_write(`IRS_ADDR_MONCTL, 16'(1 << d));
		pulse_strobe(d, pulses);
		apb_write(`IRS_ADDR_MONCTL, 16'h0000);
		while (!seen && tries < 30) begin
			apb_read(`IRS_ADDR_MONSTAT, rd, err);
			seen = rd[d];
			tries++;
		end
		if (!seen) begin
			timeouts++;
			$display("Timeout: new-value flag of daughter %0d never set", d);
		end
		// Flag went away with the read that returned it
		apb_read(`IRS_ADDR_MONSTAT, rd, err);
		check_value("MONSTAT flag after clear", rd[d], 0);
		apb_read(apb_addr_t'(`IRS_ADDR_WILKMON0 + d), rd, err);
		check_value($sformatf("WILKMON%0d", d), rd, exp_count);
	endtask

	task automatic test_monitor();
		int n;
		// Pulse count from the seeded draw, 1 to 300
		n = 1 + int'(seed_val % 300);
		// Daughters 0 to 2 enabled, 3 left off
		apb_write(`IRS_ADDR_CTL, 16'h0701);
		monitor_run(2, n, n);
		monitor_run(3, 50, 0);
		monitor_run(0, 1100, 1023);
	endtask

	task automatic test_bus_errors();
		apb_data_t rd;
		logic      err;
		apb_read(8'h10, rd, err);
		check_value("pslverr on unmapped read", err, 1);
		// Daughter 0 still holds its saturated count from the monitor test
		apb_write(`IRS_ADDR_WILKMON0, 16'h0155);
		apb_read(`IRS_ADDR_WILKMON0, rd, err);
		check_value("WILKMON0 after write", rd, 16'h03FF);
		check_value("pslverr on WILKMON0 read", err, 0);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		seed_val = $urandom(32'h21989961);
		errors   = 0;
		timeouts = 0;
		clk_i    = 1'b0;
		irs_rst  = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		strobe   = '0;
		repeat (5) @(posedge clk_i);
		#1 irs_rst = 1'b0;
		test_reset_values();
		test_ctl_settings();
		test_monitor();
		test_bus_errors();
		$display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: list.f
+incdir+hdl
hdl/irs_pkg.sv
hdl/irs_apb_regs.sv
hdl/irs_daughter_mon.sv
hdl/irs_mon_collect.sv
hdl/irs_ctrl_top.sv
verif/irs_properties.sv
verif/irs_tb.sv
